// File: verilog/rvPkg.sv
package rvPkg;

    localparam int xlen = 32;
    localparam int instWidth = 32;
    localparam int regNameWidth = 5;

    // major opcodes, instruction bits 6:0.
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;

    // operations named by the decoder.
    typedef enum logic [5:0] {
        nopOp,
        luiOp,
        auipcOp,
        jalOp,
        jalrOp,
        beqOp,
        bneOp,
        bltOp,
        bgeOp,
        bltuOp,
        bgeuOp,
        addiOp,
        sltiOp,
        sltiuOp,
        xoriOp,
        oriOp,
        andiOp,
        slliOp,
        srliOp,
        sraiOp,
        addOp,
        subOp,
        sllOp,
        sltOp,
        sltuOp,
        xorOp,
        srlOp,
        sraOp,
        orOp,
        andOp
    } opCode;

endpackage

// File: verilog/instDecoder.sv
module instDecoder import rvPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load,
    input  logic                    flush,
    input  logic [instWidth-1:0]    instData,
    input  logic [xlen-1:0]         instPc,
    input  logic                    instPredTaken,
    output opCode                   op,
    output logic [regNameWidth-1:0] rs1,
    output logic [regNameWidth-1:0] rs2,
    output logic [regNameWidth-1:0] rd,
    output logic [xlen-1:0]         imm,
    output logic [xlen-1:0]         pc,
    output logic                    predTaken,
    output logic                    writesRd
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            altBit;
    logic            funct7Clean;
    opCode           nextOp;
    logic [xlen-1:0] nextImm;
    logic            nextWrites;

    assign opcode = instData[6:0];
    assign funct3 = instData[14:12];
    assign altBit = instData[30];
    // funct7 may only use bit 30.
    assign funct7Clean = !instData[31] && (instData[29:25] == 5'd0);

    always_comb begin
        case (opcode)
            opLui, opAuipc: nextImm = {instData[31:12], 12'd0};
            opJal: nextImm = {{12{instData[31]}}, instData[19:12], instData[20],
                              instData[30:21], 1'b0};
            opBranch: nextImm = {{20{instData[31]}}, instData[7], instData[30:25],
                                 instData[11:8], 1'b0};
            opJalr, opImm, opLoad: nextImm = {{21{instData[31]}}, instData[30:20]};
            opStore: nextImm = {{21{instData[31]}}, instData[30:25], instData[11:7]};
            default: nextImm = '0;
        endcase
    end

    always_comb begin
        nextOp = nopOp;
        case (opcode)
            opLui: nextOp = luiOp;
            opAuipc: nextOp = auipcOp;
            opJal: nextOp = jalOp;
            opJalr: if (funct3 == 3'b000) nextOp = jalrOp;
            opBranch: begin
                case (funct3)
                    3'b000: nextOp = beqOp;
                    3'b001: nextOp = bneOp;
                    3'b100: nextOp = bltOp;
                    3'b101: nextOp = bgeOp;
                    3'b110: nextOp = bltuOp;
                    3'b111: nextOp = bgeuOp;
                    default: nextOp = nopOp;
                endcase
            end
            opImm: begin
                // bit 30 is immediate data except on shifts.
                case (funct3)
                    3'b000: nextOp = addiOp;
                    3'b010: nextOp = sltiOp;
                    3'b011: nextOp = sltiuOp;
                    3'b100: nextOp = xoriOp;
                    3'b110: nextOp = oriOp;
                    3'b111: nextOp = andiOp;
                    3'b001: if (funct7Clean && !altBit) nextOp = slliOp;
                    3'b101: if (funct7Clean) nextOp = altBit ? sraiOp : srliOp;
                    default: nextOp = nopOp;
                endcase
            end
            opReg: begin
                if (funct7Clean) begin
                    case ({altBit, funct3})
                        4'b0000: nextOp = addOp;
                        4'b1000: nextOp = subOp;
                        4'b0001: nextOp = sllOp;
                        4'b0010: nextOp = sltOp;
                        4'b0011: nextOp = sltuOp;
                        4'b0100: nextOp = xorOp;
                        4'b0101: nextOp = srlOp;
                        4'b1101: nextOp = sraOp;
                        4'b0110: nextOp = orOp;
                        4'b0111: nextOp = andOp;
                        default: nextOp = nopOp;
                    endcase
                end
            end
            // loads, stores and system codes fall through.
            default: nextOp = nopOp;
        endcase
    end

    always_comb begin
        case (nextOp)
            nopOp, beqOp, bneOp, bltOp, bgeOp, bltuOp, bgeuOp: nextWrites = 1'b0;
            default: nextWrites = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            op       <= nopOp;
            writesRd <= 1'b0;
        end else if (load) begin
            op       <= nextOp;
            writesRd <= nextWrites;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rs1       <= instData[19:15];
            rs2       <= instData[24:20];
            rd        <= instData[11:7];
            imm       <= nextImm;
            pc        <= instPc;
            predTaken <= instPredTaken;
        end
    end

endmodule

// File: verilog/regFile.sv
module regFile import rvPkg::*; #(
    parameter int numRegs = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [regNameWidth-1:0] rdAddr1,
    input  logic [regNameWidth-1:0] rdAddr2,
    output logic [xlen-1:0]         rdData1,
    output logic [xlen-1:0]         rdData2,
    input  logic                    wrEn,
    input  logic [regNameWidth-1:0] wrAddr,
    input  logic [xlen-1:0]         wrData
);

    logic [xlen-1:0] regs [numRegs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0 && wrAddr < numRegs) begin
            regs[wrAddr] <= wrData;
        end
    end

    // x0 and names past the end read zero.
    assign rdData1 = (rdAddr1 == '0 || rdAddr1 >= numRegs) ? '0 : regs[rdAddr1];
    assign rdData2 = (rdAddr2 == '0 || rdAddr2 >= numRegs) ? '0 : regs[rdAddr2];

    // the issue logic must filter names the file does not hold.
    wrInRange: assert property (@(posedge clk) disable iff (rst)
        wrEn |-> wrAddr < numRegs);

endmodule

// File: verilog/intAlu.sv
module intAlu import rvPkg::*; (
    input  opCode           op,
    input  logic [xlen-1:0] opA,
    input  logic [xlen-1:0] opB,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] pc,
    output logic [xlen-1:0] result
);

    logic [4:0] regShamt;
    logic [4:0] immShamt;

    assign regShamt = opB[4:0];
    assign immShamt = imm[4:0];

    always_comb begin
        case (op)
            luiOp: result = imm;
            auipcOp: result = pc + imm;
            // link value.
            jalOp, jalrOp: result = pc + xlen'(4);
            addiOp: result = opA + imm;
            sltiOp: result = ($signed(opA) < $signed(imm)) ? xlen'(1) : '0;
            sltiuOp: result = (opA < imm) ? xlen'(1) : '0;
            xoriOp: result = opA ^ imm;
            oriOp: result = opA | imm;
            andiOp: result = opA & imm;
            slliOp: result = opA << immShamt;
            srliOp: result = opA >> immShamt;
            sraiOp: result = $signed(opA) >>> immShamt;
            addOp: result = opA + opB;
            subOp: result = opA - opB;
            sllOp: result = opA << regShamt;
            sltOp: result = ($signed(opA) < $signed(opB)) ? xlen'(1) : '0;
            sltuOp: result = (opA < opB) ? xlen'(1) : '0;
            xorOp: result = opA ^ opB;
            srlOp: result = opA >> regShamt;
            sraOp: result = $signed(opA) >>> regShamt;
            orOp: result = opA | opB;
            andOp: result = opA & opB;
            // branches and nop.
            default: result = '0;
        endcase
    end

endmodule

// File: verilog/branchUnit.sv
module branchUnit import rvPkg::*; (
    input  opCode           op,
    input  logic [xlen-1:0] opA,
    input  logic [xlen-1:0] opB,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] pc,
    input  logic            predTaken,
    output logic            mispredict,
    output logic [xlen-1:0] target
);

    logic            taken;
    logic            isControl;
    logic [xlen-1:0] takenTarget;

    always_comb begin
        taken     = 1'b0;
        isControl = 1'b1;
        case (op)
            beqOp: taken = opA == opB;
            bneOp: taken = opA != opB;
            bltOp: taken = $signed(opA) < $signed(opB);
            bgeOp: taken = $signed(opA) >= $signed(opB);
            bltuOp: taken = opA < opB;
            bgeuOp: taken = opA >= opB;
            jalOp, jalrOp: taken = 1'b1;
            default: isControl = 1'b0;
        endcase
    end

    // jalr drops bit 0 of the sum.
    assign takenTarget = (op == jalrOp) ? ((opA + imm) & ~xlen'(1)) : pc + imm;
    assign target = taken ? takenTarget : pc + xlen'(4);
    assign mispredict = isControl && (taken != predTaken);

endmodule

// File: verilog/issueControl.sv
module issueControl import rvPkg::*; #(
    parameter int numRegs = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instValid,
    output logic                    instReady,
    input  logic                    wbReady,
    output logic                    wbValid,
    input  logic [regNameWidth-1:0] decodeRs1,
    input  logic [regNameWidth-1:0] decodeRs2,
    input  logic [regNameWidth-1:0] execRd,
    input  logic                    execWrite,
    input  logic                    mispredictIn,
    output logic                    decodeAdvance,
    output logic                    decodeFlush,
    output logic                    execLoad,
    output logic                    fwdRs1,
    output logic                    fwdRs2,
    output logic                    regWrite,
    output logic                    redirectValid
);

    logic decodeValid;
    logic execValid;
    logic wbFire;
    logic execFree;
    logic execWritesReg;

    assign wbValid  = execValid;
    assign wbFire   = execValid && wbReady;
    assign execFree = !execValid || wbReady;

    assign instReady     = !decodeValid || execFree;
    assign decodeAdvance = instValid && instReady;
    // a retiring mispredict also kills anything accepted now.
    assign decodeFlush   = wbFire && mispredictIn;
    assign redirectValid = decodeFlush;
    assign execLoad      = decodeValid && execFree && !decodeFlush;

    assign execWritesReg = execWrite && execRd != '0 && execRd < numRegs;
    assign regWrite      = wbFire && execWritesReg;
    assign fwdRs1        = execValid && execWritesReg && execRd == decodeRs1;
    assign fwdRs2        = execValid && execWritesReg && execRd == decodeRs2;

    always_ff @(posedge clk) begin
        if (rst) begin
            decodeValid <= 1'b0;
            execValid   <= 1'b0;
        end else begin
            if (execFree) begin
                execValid <= execLoad;
            end
            if (decodeFlush) begin
                decodeValid <= 1'b0;
            end else if (instReady) begin
                decodeValid <= instValid;
            end
        end
    end

    wbHold: assert property (@(posedge clk) disable iff (rst)
        wbValid && !wbReady |=> wbValid);

    // flushed decode leaves execute empty on the next cycle.
    redirectRetires: assert property (@(posedge clk) disable iff (rst)
        redirectValid |-> (wbValid && wbReady) ##1 !wbValid);

endmodule

// File: verilog/execCore.sv
module execCore import rvPkg::*; #(
    parameter int numRegs = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instValid,
    input  logic [instWidth-1:0]    instData,
    input  logic [xlen-1:0]         instPc,
    input  logic                    instPredTaken,
    output logic                    instReady,
    output logic                    wbValid,
    output logic                    wbWrite,
    output logic [regNameWidth-1:0] wbRd,
    output logic [xlen-1:0]         wbData,
    output logic [xlen-1:0]         wbPc,
    input  logic                    wbReady,
    output logic                    redirectValid,
    output logic [xlen-1:0]         redirectPc
);

    logic                    decodeAdvance;
    logic                    decodeFlush;
    logic                    execLoad;
    logic                    fwdRs1;
    logic                    fwdRs2;
    logic                    regWrite;
    opCode                   decOp;
    logic [regNameWidth-1:0] decRs1;
    logic [regNameWidth-1:0] decRs2;
    logic [regNameWidth-1:0] decRd;
    logic [xlen-1:0]         decImm;
    logic [xlen-1:0]         decPc;
    logic                    decPredTaken;
    logic                    decWritesRd;
    logic [xlen-1:0]         rfData1;
    logic [xlen-1:0]         rfData2;
    logic [xlen-1:0]         opA;
    logic [xlen-1:0]         opB;
    logic [xlen-1:0]         aluResult;
    logic                    brMispredict;
    logic [xlen-1:0]         brTarget;
    logic [xlen-1:0]         execResult;
    logic [regNameWidth-1:0] execRd;
    logic                    execWrite;
    logic [xlen-1:0]         execPc;
    logic                    execMispredict;
    logic [xlen-1:0]         execTarget;

    issueControl #(.numRegs(numRegs)) control0 (
        .clk(clk), .rst(rst),
        .instValid(instValid), .instReady(instReady),
        .wbReady(wbReady), .wbValid(wbValid),
        .decodeRs1(decRs1), .decodeRs2(decRs2),
        .execRd(execRd), .execWrite(execWrite), .mispredictIn(execMispredict),
        .decodeAdvance(decodeAdvance), .decodeFlush(decodeFlush), .execLoad(execLoad),
        .fwdRs1(fwdRs1), .fwdRs2(fwdRs2),
        .regWrite(regWrite), .redirectValid(redirectValid)
    );

    instDecoder decoder0 (
        .clk(clk), .rst(rst), .load(decodeAdvance), .flush(decodeFlush),
        .instData(instData), .instPc(instPc), .instPredTaken(instPredTaken),
        .op(decOp), .rs1(decRs1), .rs2(decRs2), .rd(decRd),
        .imm(decImm), .pc(decPc), .predTaken(decPredTaken), .writesRd(decWritesRd)
    );

    regFile #(.numRegs(numRegs)) regs0 (
        .clk(clk), .rst(rst),
        .rdAddr1(decRs1), .rdAddr2(decRs2), .rdData1(rfData1), .rdData2(rfData2),
        .wrEn(regWrite), .wrAddr(execRd), .wrData(execResult)
    );

    // bypass from the execute register.
    assign opA = fwdRs1 ? execResult : rfData1;
    assign opB = fwdRs2 ? execResult : rfData2;

    intAlu alu0 (
        .op(decOp), .opA(opA), .opB(opB), .imm(decImm), .pc(decPc), .result(aluResult)
    );

    branchUnit branch0 (
        .op(decOp), .opA(opA), .opB(opB), .imm(decImm), .pc(decPc),
        .predTaken(decPredTaken), .mispredict(brMispredict), .target(brTarget)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            execWrite      <= 1'b0;
            execMispredict <= 1'b0;
        end else if (execLoad) begin
            execWrite      <= decWritesRd;
            execMispredict <= brMispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (execLoad) begin
            execResult <= aluResult;
            execRd     <= decRd;
            execPc     <= decPc;
            execTarget <= brTarget;
        end
    end

    assign wbWrite    = execWrite;
    assign wbRd       = execRd;
    assign wbData     = execResult;
    assign wbPc       = execPc;
    assign redirectPc = execTarget;

endmodule

// File: verification/clkGen.sv
module clkGen #(
    parameter int period = 40
) (
    output logic clk
);

    // free running with the first rising edge at half a period.
    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

// File: verification/execCoreTb.sv
module execCoreTb import rvPkg::*; ();

    localparam int numInst = 400;
    localparam int cycleLimit = 2 * numInst + 200;

    logic                    clk;
    logic                    rst;
    logic                    instValid;
    logic [instWidth-1:0]    instData;
    logic [xlen-1:0]         instPc;
    logic                    instPredTaken;
    logic                    instReady;
    logic                    wbValid;
    logic                    wbWrite;
    logic [regNameWidth-1:0] wbRd;
    logic [xlen-1:0]         wbData;
    logic [xlen-1:0]         wbPc;
    logic                    wbReady;
    logic                    redirectValid;
    logic [xlen-1:0]         redirectPc;
    logic                    wbFire;

    int seed = 32'h7ee3;
    int valueErrors = 0;
    int protocolErrors = 0;
    int cycles = 0;
    int genCount;
    int retireIdx;
    logic pending;
    logic wrongPath;
    logic [31:0] nextPc;
    logic [31:0] junkPc;
    logic [31:0] model [8];

    // expected writebacks in retire order.
    logic [4:0]  expRdArr [numInst + 1];
    logic        expWriteArr [numInst + 1];
    logic [31:0] expDataArr [numInst + 1];
    logic [31:0] expPcArr [numInst + 1];
    logic        expRedirArr [numInst + 1];
    logic [31:0] expTargetArr [numInst + 1];
    logic [4:0]  expRd;
    logic        expWrite;
    logic [31:0] expData;
    logic [31:0] expPc;
    logic        expRedir;
    logic [31:0] expTarget;

    clkGen #(.period(40)) clkGen0 (.clk(clk));

    execCore #(.numRegs(32)) dut0 (
        .clk(clk), .rst(rst),
        .instValid(instValid), .instData(instData), .instPc(instPc),
        .instPredTaken(instPredTaken), .instReady(instReady),
        .wbValid(wbValid), .wbWrite(wbWrite), .wbRd(wbRd), .wbData(wbData), .wbPc(wbPc),
        .wbReady(wbReady), .redirectValid(redirectValid), .redirectPc(redirectPc)
    );

    assign wbFire    = wbValid && wbReady;
    assign expRd     = expRdArr[retireIdx];
    assign expWrite  = expWriteArr[retireIdx];
    assign expData   = expDataArr[retireIdx];
    assign expPc     = expPcArr[retireIdx];
    assign expRedir  = expRedirArr[retireIdx];
    assign expTarget = expTargetArr[retireIdx];

    task automatic valueError(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        valueErrors++;
        $display("Error at %0t: %s expected %h, actual %h", $time, name, expVal, actVal);
    endtask

    task automatic protocolError(input string msg);
        protocolErrors++;
        $display("At %0t: %s", $time, msg);
    endtask

    task automatic finishRun();
        $display("errors: %0d value, %0d protocol; retired %0d of %0d instructions",
                 valueErrors, protocolErrors, retireIdx, numInst);
        if (valueErrors == 0 && protocolErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic logic [31:0] encI(input logic [31:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encB(input logic [31:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] encJ(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    // RV32I arithmetic for funct3 and the alternate bit.
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return sa >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // next correct-path instruction and its architectural effect.
    task automatic makeNext();
        int kind;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic alt;
        logic [31:0] r;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        logic [31:0] word;
        logic [31:0] target;
        logic [31:0] pc;
        logic writes;
        logic isCtl;
        logic taken;
        logic pred;
        kind = $random(seed) & 15;
        rd = 5'($random(seed) & 7);
        rs1 = 5'($random(seed) & 7);
        rs2 = 5'($random(seed) & 7);
        f3 = 3'($random(seed));
        r = $random(seed);
        pc = nextPc;
        a = model[rs1[2:0]];
        b = model[rs2[2:0]];
        alt = 1'b0;
        imm = {{20{r[11]}}, r[11:0]};
        writes = 1'b1;
        isCtl = 1'b0;
        taken = 1'b0;
        result = '0;
        target = pc + 32'd4;
        if (kind <= 4) begin
            alt = (f3 == 3'd0 || f3 == 3'd5) ? r[30] : 1'b0;
            word = encR({1'b0, alt, 5'd0}, rs2, rs1, f3, rd);
            result = aluRef(f3, alt, a, b);
        end else if (kind <= 8) begin
            if (f3 == 3'd1) begin
                imm = {27'd0, r[4:0]};
            end else if (f3 == 3'd5) begin
                alt = r[30];
                imm = {21'd0, alt, 5'd0, r[4:0]};
            end
            word = encI(imm, rs1, f3, rd, opImm);
            result = aluRef(f3, alt, a, imm);
        end else if (kind <= 10) begin
            imm = {r[31:12], 12'd0};
            word = {imm[31:12], rd, (kind == 9) ? opLui : opAuipc};
            result = (kind == 9) ? imm : pc + imm;
        end else if (kind == 11) begin
            imm = {{11{r[20]}}, r[20:1], 1'b0};
            word = encJ(imm, rd);
            result = pc + 32'd4;
            isCtl = 1'b1;
            taken = 1'b1;
            target = pc + imm;
        end else if (kind == 12) begin
            word = encI(imm, rs1, 3'd0, rd, opJalr);
            result = pc + 32'd4;
            isCtl = 1'b1;
            taken = 1'b1;
            target = (a + imm) & ~32'd1;
        end else if (kind <= 14) begin
            // funct3 2 and 3 are not branches.
            if (f3 == 3'd2 || f3 == 3'd3) begin
                f3 = f3 ^ 3'b100;
            end
            imm = {{19{r[12]}}, r[12:1], 1'b0};
            word = encB(imm, rs2, rs1, f3);
            writes = 1'b0;
            isCtl = 1'b1;
            taken = branchTaken(f3, a, b);
            if (taken) begin
                target = pc + imm;
            end
        end else begin
            writes = 1'b0;
            case (f3[1:0])
                2'd0: word = encI(imm, rs1, 3'b010, rd, opLoad);
                2'd1: word = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
                2'd2: word = encR(7'h01, rs2, rs1, f3, rd);
                default: word = 32'h0000_0073;
            endcase
        end
        pred = r[31];
        expRdArr[genCount] = rd;
        expWriteArr[genCount] = writes;
        expDataArr[genCount] = result;
        expPcArr[genCount] = pc;
        expRedirArr[genCount] = isCtl && (taken != pred);
        expTargetArr[genCount] = target;
        if (writes && rd != 5'd0) begin
            model[rd[2:0]] = result;
        end
        if (isCtl && (taken != pred)) begin
            wrongPath = 1'b1;
            junkPc = pred ? pc + imm : pc + 32'd4;
        end
        nextPc = target;
        instData = word;
        instPc = pc;
        instPredTaken = pred;
        genCount++;
    endtask

    // wrong-path filler that must never retire.
    task automatic makeJunk();
        logic [31:0] r;
        r = $random(seed);
        instData = encI(r, {2'b00, r[14:12]}, 3'd0, {2'b00, r[17:15] | 3'b001}, opImm);
        instPc = junkPc;
        instPredTaken = 1'b0;
        junkPc = junkPc + 32'd4;
    endtask

    initial begin
        logic accepted;
        logic redirected;
        logic holding;
        rst = 1'b1;
        instValid = 1'b0;
        instData = '0;
        instPc = '0;
        instPredTaken = 1'b0;
        wbReady = 1'b0;
        pending = 1'b0;
        wrongPath = 1'b0;
        nextPc = 32'h0000_1000;
        junkPc = '0;
        genCount = 0;
        for (int i = 0; i < 8; i++) begin
            model[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        wbReady = 1'b1;
        while (retireIdx < numInst) begin
            @(negedge clk);
            accepted = instValid && instReady;
            redirected = redirectValid;
            @(posedge clk);
            #1;
            holding = instValid && !accepted && !redirected;
            if (accepted || redirected) begin
                pending = 1'b0;
            end
            if (redirected) begin
                wrongPath = 1'b0;
            end
            if (!pending && wrongPath) begin
                makeJunk();
                pending = 1'b1;
            end else if (!pending && genCount < numInst) begin
                makeNext();
                pending = 1'b1;
            end
            if (!holding) begin
                instValid = pending && (($random(seed) & 15) != 0);
            end
            wbReady = ($random(seed) & 15) >= 3;
        end
        instValid = 1'b0;
        wbReady = 1'b1;
        repeat (4) @(posedge clk);
        finishRun();
    end

    always @(posedge clk) begin
        if (rst) begin
            retireIdx <= 0;
        end else if (wbFire && retireIdx < numInst) begin
            retireIdx <= retireIdx + 1;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycles = cycles + 1;
            if (cycles >= cycleLimit) begin
                protocolError($sformatf("timeout after %0d cycles", cycles));
                finishRun();
            end
        end
    end

    chkAfterReset: assert property (@(posedge clk)
        $fell(rst) |-> instReady && !wbValid && !redirectValid)
        else protocolError("pipeline not idle after reset");

    chkKnown: assert property (@(posedge clk) disable iff (rst)
        wbFire |-> retireIdx < genCount)
        else protocolError("writeback with no instruction left to retire");

    chkHold: assert property (@(posedge clk) disable iff (rst)
        wbValid && !wbReady |=> wbValid && $stable({wbWrite, wbRd, wbData, wbPc}))
        else protocolError("writeback dropped or changed while waiting for wbReady");

    chkRedirOnly: assert property (@(posedge clk) disable iff (rst)
        redirectValid |-> wbFire)
        else protocolError("redirect without a completed writeback");

    chkPc: assert property (@(posedge clk) disable iff (rst) wbFire |-> wbPc == expPc)
        else valueError("wbPc", $sampled(expPc), $sampled(wbPc));

    chkWrite: assert property (@(posedge clk) disable iff (rst)
        wbFire |-> wbWrite == expWrite)
        else valueError("wbWrite", 32'($sampled(expWrite)), 32'($sampled(wbWrite)));

    chkRd: assert property (@(posedge clk) disable iff (rst)
        wbFire && expWrite |-> wbRd == expRd)
        else valueError("wbRd", 32'($sampled(expRd)), 32'($sampled(wbRd)));

    chkData: assert property (@(posedge clk) disable iff (rst)
        wbFire |-> wbData == expData)
        else valueError("wbData", $sampled(expData), $sampled(wbData));

    chkRedirect: assert property (@(posedge clk) disable iff (rst)
        wbFire |-> redirectValid == expRedir)
        else valueError("redirectValid", 32'($sampled(expRedir)),
                        32'($sampled(redirectValid)));

    chkTarget: assert property (@(posedge clk) disable iff (rst)
        wbFire && expRedir |-> redirectPc == expTarget)
        else valueError("redirectPc", $sampled(expTarget), $sampled(redirectPc));

endmodule

// File: tb.f
verilog/rvPkg.sv
verilog/instDecoder.sv
verilog/regFile.sv
verilog/intAlu.sv
verilog/branchUnit.sv
verilog/issueControl.sv
verilog/execCore.sv
verification/clkGen.sv
verification/execCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= execCoreTb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASSTEXT  ?= *** PASSED ***

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qF -- '$(PASSTEXT)' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
